// File: flist.f
+incdir+design
+incdir+bench
design/rv_isa_pkg.sv
design/pipe_pkg.sv
design/decode_unit.sv
design/operand_select.sv
design/execute_unit.sv
design/mem_writeback.sv
design/rv32_pipe.sv
bench/tb_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_core -o sim_core

out=$(./obj_dir/sim_core)
printf '%s\n' "$out"

# a missing pass line ends the script with a failing status
printf '%s\n' "$out" | grep -qx "All tests passed"

// File: bench/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROG_LEN = 33;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

task automatic expect_retire(input logic [4:0] rd, input logic [31:0] val);
    exp_rd.push_back(rd);
    exp_val.push_back(val);
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
endtask

// fills imem and the expected retire and store queues
task automatic load_program();
    for (int k = 0; k < 64; k++) begin
        imem[k] = enc_i(12'd0, 5'd0, 3'b000, 5'd0, 7'b0010011);
        dmem[k] = 32'hd0d0_0000 ^ (32'(k) << 2) ^ (32'(k) << 20);
    end
    exp_rd.delete();
    exp_val.delete();
    exp_addr.delete();
    exp_data.delete();
    imem[0]  = enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011);
    imem[1]  = enc_i(12'd7, 5'd1, 3'b000, 5'd2, 7'b0010011);
    imem[2]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
    imem[3]  = enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);
    imem[4]  = enc_r(7'h00, 5'd3, 5'd4, 3'b100, 5'd5);
    imem[5]  = enc_r(7'h00, 5'd1, 5'd5, 3'b110, 5'd6);
    imem[6]  = enc_r(7'h00, 5'd2, 5'd6, 3'b111, 5'd7);
    imem[7]  = enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd8);
    imem[8]  = enc_r(7'h00, 5'd8, 5'd1, 3'b001, 5'd9);
    imem[9]  = enc_r(7'h00, 5'd8, 5'd3, 3'b101, 5'd10);
    imem[10] = {20'h12345, 5'd11, 7'b0110111};
    imem[11] = enc_i(12'h00f, 5'd3, 3'b111, 5'd12, 7'b0010011);
    imem[12] = enc_i(12'h030, 5'd1, 3'b110, 5'd13, 7'b0010011);
    imem[13] = enc_i(12'hfff, 5'd1, 3'b100, 5'd14, 7'b0010011);
    imem[14] = enc_i(12'h000, 5'd14, 3'b010, 5'd15, 7'b0010011);
    imem[15] = enc_s(12'd64, 5'd3, 5'd0);
    imem[16] = enc_s(12'd68, 5'd10, 5'd0);
    imem[17] = enc_i(12'd64, 5'd0, 3'b010, 5'd16, 7'b0000011);
    imem[18] = enc_r(7'h00, 5'd1, 5'd16, 3'b000, 5'd17);
    imem[19] = enc_i(12'd68, 5'd0, 3'b010, 5'd18, 7'b0000011);
    imem[20] = enc_s(12'd72, 5'd18, 5'd0);
    imem[21] = enc_b(13'd8, 5'd1, 5'd1, 3'b000);
    imem[22] = enc_i(12'd1, 5'd0, 3'b000, 5'd31, 7'b0010011);
    imem[23] = enc_j(21'd8, 5'd19);
    imem[24] = enc_i(12'd2, 5'd0, 3'b000, 5'd31, 7'b0010011);
    imem[25] = enc_i(12'd116, 5'd0, 3'b000, 5'd20, 7'b0010011);
    imem[26] = enc_i(12'd0, 5'd20, 3'b000, 5'd21, 7'b1100111);
    imem[27] = enc_i(12'd3, 5'd0, 3'b000, 5'd31, 7'b0010011);
    imem[28] = enc_i(12'd4, 5'd0, 3'b000, 5'd31, 7'b0010011);
    imem[29] = enc_b(13'd8, 5'd1, 5'd1, 3'b001);
    imem[30] = enc_i(12'hffd, 5'd0, 3'b000, 5'd22, 7'b0010011);
    imem[31] = enc_s(12'd76, 5'd22, 5'd0);
    // halt loop of jal x0 to itself
    imem[32] = enc_j(21'd0, 5'd0);

    expect_retire(5'd1, 32'd5);
    expect_retire(5'd2, 32'd12);
    expect_retire(5'd3, 32'd17);
    expect_retire(5'd4, 32'd12);
    expect_retire(5'd5, 32'd29);
    expect_retire(5'd6, 32'd29);
    expect_retire(5'd7, 32'd12);
    expect_retire(5'd8, 32'd1);
    expect_retire(5'd9, 32'd10);
    expect_retire(5'd10, 32'd8);
    expect_retire(5'd11, 32'h1234_5000);
    expect_retire(5'd12, 32'd1);
    expect_retire(5'd13, 32'd53);
    expect_retire(5'd14, 32'hffff_fffa);
    expect_retire(5'd15, 32'd1);
    expect_retire(5'd16, 32'd17);
    expect_retire(5'd17, 32'd22);
    expect_retire(5'd18, 32'd8);
    expect_retire(5'd19, 32'd96);
    expect_retire(5'd20, 32'd116);
    expect_retire(5'd21, 32'd108);
    expect_retire(5'd22, 32'hffff_fffd);

    expect_store(32'd64, 32'd17);
    expect_store(32'd68, 32'd8);
    expect_store(32'd72, 32'd8);
    expect_store(32'd76, 32'hffff_fffd);
endtask

`endif

// File: bench/tb_core.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module tb_core;

    localparam int PERIOD = 40;
    // cycle budget per instruction with room for back-pressure
    localparam int CYC_PER_INST = 6;

    logic              clk;
    logic              rst_i;
    logic [`XLEN-1:0]  imem_addr;
    rv_isa_pkg::inst_u imem_data;
    pipe_pkg::dreq_t   dreq;
    pipe_pkg::dresp_t  dresp;
    pipe_pkg::retire_t retire;
    logic              ready;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_val [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    int          seed;
    int          errors;
    int          ret_idx;
    int          st_idx;
    int          ret_total;
    int          st_total;
    logic        bp_on;

    // flags written at negedge and checked at posedge
    logic        rst_chk;
    logic        rst_ok;
    logic        ret_chk;
    logic        ret_ok;
    logic [4:0]  ret_rd;
    logic [31:0] ret_data;
    logic        st_chk;
    logic        st_ok;
    logic        hold_chk;
    logic        hold_ok;
    logic        prev_wait;
    pipe_pkg::dreq_t prev_req;
    logic        done_chk;
    logic        done_ok;

    `include "tb_program.svh"

    localparam int WATCHDOG_CYCLES = 2 * PROG_LEN * CYC_PER_INST * 2;

    rv32_pipe i_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .dreq_o      (dreq),
        .dresp_i     (dresp),
        .retire_o    (retire)
    );

    assign imem_data   = imem[imem_addr[7:2]];
    assign dresp.ready = ready;
    assign dresp.rdata = dmem[dreq.addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ready first and then bookkeeping against the new value
    always @(negedge clk) begin
        ready = bp_on ? (($unsigned($random(seed)) % 3) != 0) : 1'b1;
        ret_chk  = 1'b0;
        st_chk   = 1'b0;
        hold_chk = prev_wait;
        hold_ok  = dreq == prev_req;
        if (retire.valid) begin
            ret_chk  = 1'b1;
            ret_rd   = retire.rd;
            ret_data = retire.wdata;
            ret_ok   = ret_idx < exp_rd.size() && retire.rd == exp_rd[ret_idx] &&
                       retire.wdata == exp_val[ret_idx];
            ret_idx++;
        end
        if (dreq.valid && dreq.we && ready) begin
            st_chk = 1'b1;
            st_ok  = st_idx < exp_addr.size() && dreq.addr == exp_addr[st_idx] &&
                     dreq.wdata == exp_data[st_idx];
            dmem[dreq.addr[7:2]] = dreq.wdata;
            st_idx++;
        end
        prev_wait = dreq.valid && !ready;
        prev_req  = dreq;
    end

    a_reset_state: assert property (@(posedge clk) rst_chk |-> rst_ok)
        else begin
            errors++;
            $display("FAIL %0t: outputs not idle during reset", $time);
        end

    a_retire_value: assert property (@(posedge clk) disable iff (rst_i) ret_chk |-> ret_ok)
        else begin
            errors++;
            $display("FAIL %0t: retire %0d got x%0d = %h", $time, ret_idx - 1, ret_rd,
                     ret_data);
        end

    a_no_marker: assert property (@(posedge clk) disable iff (rst_i)
                                  ret_chk |-> ret_rd != 5'd31)
        else begin
            errors++;
            $display("FAIL %0t: wrong-path marker wrote x31", $time);
        end

    a_store_value: assert property (@(posedge clk) disable iff (rst_i) st_chk |-> st_ok)
        else begin
            errors++;
            $display("FAIL %0t: store %0d has wrong address or data", $time, st_idx - 1);
        end

    a_req_stable: assert property (@(posedge clk) disable iff (rst_i) hold_chk |-> hold_ok)
        else begin
            errors++;
            $display("FAIL %0t: data request changed while ready was low", $time);
        end

    a_run_complete: assert property (@(posedge clk) done_chk |-> done_ok)
        else begin
            errors++;
            $display("FAIL %0t: run ended with %0d retires and %0d stores", $time,
                     ret_idx, st_idx);
        end

    task automatic run_program(input logic with_bp);
        rst_i = 1'b1;
        bp_on = with_bp;
        load_program();
        ret_idx = 0;
        st_idx  = 0;
        repeat (4) begin
            @(negedge clk);
            rst_chk = 1'b1;
            rst_ok  = !retire.valid && !dreq.valid && imem_addr == `RESET_PC;
        end
        rst_i = 1'b0;
        @(negedge clk);
        rst_chk = 1'b0;
        while (ret_idx < exp_rd.size() || st_idx < exp_addr.size()) begin
            @(negedge clk);
        end
        // quiet tail catches extra retires or stores
        repeat (10) @(negedge clk);
        done_chk = 1'b1;
        done_ok  = ret_idx == exp_rd.size() && st_idx == exp_addr.size();
        @(negedge clk);
        done_chk = 1'b0;
        ret_total += ret_idx;
        st_total  += st_idx;
    endtask

    initial begin
        seed      = 32'hbe4b;
        rst_i     = 1'b1;
        ready     = 1'b0;
        bp_on     = 1'b0;
        errors    = 0;
        ret_idx   = 0;
        st_idx    = 0;
        ret_total = 0;
        st_total  = 0;
        rst_chk   = 1'b0;
        rst_ok    = 1'b1;
        ret_chk   = 1'b0;
        ret_ok    = 1'b1;
        ret_rd    = '0;
        ret_data  = '0;
        st_chk    = 1'b0;
        st_ok     = 1'b1;
        hold_chk  = 1'b0;
        hold_ok   = 1'b1;
        prev_wait = 1'b0;
        prev_req  = '0;
        done_chk  = 1'b0;
        done_ok   = 1'b1;
        load_program();

        run_program(1'b0);
        run_program(1'b1);

        $display("retired %0d, stores %0d, errors %0d", ret_total, st_total, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("timeout: the program did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: design/rv32_pipe.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module rv32_pipe (
    input  logic              clk,
    input  logic              rst_i,
    output logic [`XLEN-1:0]  imem_addr_o,
    input  rv_isa_pkg::inst_u imem_data_i,
    output pipe_pkg::dreq_t   dreq_o,
    input  pipe_pkg::dresp_t  dresp_i,
    output pipe_pkg::retire_t retire_o
);

    logic [`XLEN-1:0]    pc_q;
    logic                hazard;
    logic                mem_stall;
    logic                front_stall;
    pipe_pkg::ds_reg_t   ds;
    pipe_pkg::ex_reg_t   ex;
    pipe_pkg::mem_reg_t  mem;
    pipe_pkg::fwd_t      ex_busy;
    pipe_pkg::fwd_t      mem_fwd;
    pipe_pkg::fwd_t      wb_fwd;
    pipe_pkg::redirect_t redirect;

    assign front_stall = mem_stall || hazard;

    // redirect beats any hold
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= `RESET_PC;
        end else if (redirect.valid) begin
            pc_q <= redirect.target;
        end else if (!front_stall) begin
            pc_q <= pc_q + `XLEN'(4);
        end
    end

    assign imem_addr_o = pc_q;

    decode_unit i_decode (
        .clk     (clk),
        .rst_i   (rst_i),
        .stall_i (front_stall),
        .flush_i (redirect.valid),
        .pc_i    (pc_q),
        .inst_i  (imem_data_i),
        .ds_o    (ds)
    );

    operand_select i_select (
        .clk         (clk),
        .rst_i       (rst_i),
        .ds_i        (ds),
        .ex_busy_i   (ex_busy),
        .mem_fwd_i   (mem_fwd),
        .wb_fwd_i    (wb_fwd),
        .wb_i        (retire_o),
        .mem_stall_i (mem_stall),
        .flush_i     (redirect.valid),
        .ex_o        (ex),
        .hazard_o    (hazard)
    );

    execute_unit i_execute (
        .clk         (clk),
        .rst_i       (rst_i),
        .ex_i        (ex),
        .hazard_i    (hazard),
        .mem_stall_i (mem_stall),
        .mem_o       (mem),
        .busy_o      (ex_busy),
        .redirect_o  (redirect)
    );

    mem_writeback i_mem_wb (
        .clk       (clk),
        .rst_i     (rst_i),
        .mem_i     (mem),
        .dreq_o    (dreq_o),
        .dresp_i   (dresp_i),
        .stall_o   (mem_stall),
        .mem_fwd_o (mem_fwd),
        .wb_fwd_o  (wb_fwd),
        .retire_o  (retire_o)
    );

endmodule

// File: design/mem_writeback.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module mem_writeback (
    input  logic               clk,
    input  logic               rst_i,
    input  pipe_pkg::mem_reg_t mem_i,
    output pipe_pkg::dreq_t    dreq_o,
    input  pipe_pkg::dresp_t   dresp_i,
    output logic               stall_o,
    output pipe_pkg::fwd_t     mem_fwd_o,
    output pipe_pkg::fwd_t     wb_fwd_o,
    output pipe_pkg::retire_t  retire_o
);

    pipe_pkg::mem_reg_t mem_q;
    pipe_pkg::retire_t  wb_q;
    logic [`XLEN-1:0]   fwd_data;
    logic [`XLEN-1:0]   wb_data;

    assign dreq_o.valid = mem_q.valid && (mem_q.ctrl.mem_ren || mem_q.ctrl.mem_wen);
    assign dreq_o.we    = mem_q.ctrl.mem_wen;
    assign dreq_o.addr  = mem_q.alu_out;
    assign dreq_o.wdata = mem_q.rs2_data;

    assign stall_o = dreq_o.valid && !dresp_i.ready;

    // load data only exists in the transfer cycle
    assign fwd_data = (mem_q.ctrl.wb_sel == pipe_pkg::WB_PC4) ? mem_q.pc + `XLEN'(4)
                                                               : mem_q.alu_out;
    assign wb_data  = (mem_q.ctrl.wb_sel == pipe_pkg::WB_MEM) ? dresp_i.rdata : fwd_data;

    assign mem_fwd_o.valid       = mem_q.valid && mem_q.ctrl.rf_wen;
    assign mem_fwd_o.can_forward = !mem_q.ctrl.mem_ren;
    assign mem_fwd_o.rd          = mem_q.ctrl.rd;
    assign mem_fwd_o.wdata       = fwd_data;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_q.valid <= 1'b0;
            wb_q.valid  <= 1'b0;
        end else begin
            if (!stall_o) begin
                mem_q <= mem_i;
            end
            // bubble into wb while the port waits
            wb_q.valid <= mem_q.valid && mem_q.ctrl.rf_wen && !stall_o;
            wb_q.rd    <= mem_q.ctrl.rd;
            wb_q.wdata <= wb_data;
        end
    end

    assign wb_fwd_o.valid       = wb_q.valid;
    assign wb_fwd_o.can_forward = 1'b1;
    assign wb_fwd_o.rd          = wb_q.rd;
    assign wb_fwd_o.wdata       = wb_q.wdata;

    assign retire_o = wb_q;

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module execute_unit (
    input  logic                clk,
    input  logic                rst_i,
    input  pipe_pkg::ex_reg_t   ex_i,
    input  logic                hazard_i,
    input  logic                mem_stall_i,
    output pipe_pkg::mem_reg_t  mem_o,
    output pipe_pkg::fwd_t      busy_o,
    output pipe_pkg::redirect_t redirect_o
);

    pipe_pkg::ex_reg_t ex_q;
    logic [`XLEN-1:0]  alu_out;
    logic [`XLEN-1:0]  sum;
    logic              taken;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_q.valid <= 1'b0;
        end else if (!mem_stall_i) begin
            // the select stage holds a wrong-path op on redirect
            if (hazard_i || redirect_o.valid) begin
                ex_q.valid <= 1'b0;
            end else begin
                ex_q <= ex_i;
            end
        end
    end

    always_comb begin
        case (ex_q.ctrl.alu_op)
            rv_isa_pkg::ALU_SUB: alu_out = ex_q.op1 - ex_q.op2;
            rv_isa_pkg::ALU_AND: alu_out = ex_q.op1 & ex_q.op2;
            rv_isa_pkg::ALU_OR:  alu_out = ex_q.op1 | ex_q.op2;
            rv_isa_pkg::ALU_XOR: alu_out = ex_q.op1 ^ ex_q.op2;
            rv_isa_pkg::ALU_SLT: alu_out = `XLEN'($signed(ex_q.op1) < $signed(ex_q.op2));
            rv_isa_pkg::ALU_SLL: alu_out = ex_q.op1 << ex_q.op2[$clog2(`XLEN)-1:0];
            rv_isa_pkg::ALU_SRL: alu_out = ex_q.op1 >> ex_q.op2[$clog2(`XLEN)-1:0];
            default:             alu_out = ex_q.op1 + ex_q.op2;
        endcase
    end

    // jalr adds to rs1, branches and jal to pc
    assign sum = (ex_q.ctrl.jmp_reg ? ex_q.op1 : ex_q.pc) + ex_q.imm;

    assign taken = ex_q.ctrl.jmp || ex_q.ctrl.jmp_reg ||
                   (ex_q.ctrl.br_kind == pipe_pkg::BR_EQ && ex_q.op1 == ex_q.op2) ||
                   (ex_q.ctrl.br_kind == pipe_pkg::BR_NE && ex_q.op1 != ex_q.op2);

    // held back while mem stalls
    assign redirect_o.valid  = ex_q.valid && taken && !mem_stall_i;
    assign redirect_o.target = {sum[`XLEN-1:1], 1'b0};

    assign busy_o.valid       = ex_q.valid && ex_q.ctrl.rf_wen;
    assign busy_o.can_forward = 1'b0;
    assign busy_o.rd          = ex_q.ctrl.rd;
    assign busy_o.wdata       = alu_out;

    assign mem_o = '{valid: ex_q.valid, pc: ex_q.pc, ctrl: ex_q.ctrl,
                     alu_out: alu_out, rs2_data: ex_q.rs2_data};

endmodule

// File: design/operand_select.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module operand_select (
    input  logic               clk,
    input  logic               rst_i,
    input  pipe_pkg::ds_reg_t  ds_i,
    input  pipe_pkg::fwd_t     ex_busy_i,
    input  pipe_pkg::fwd_t     mem_fwd_i,
    input  pipe_pkg::fwd_t     wb_fwd_i,
    input  pipe_pkg::retire_t  wb_i,
    input  logic               mem_stall_i,
    input  logic               flush_i,
    output pipe_pkg::ex_reg_t  ex_o,
    output logic               hazard_o
);

    pipe_pkg::ds_reg_t sel_q;
    logic [`XLEN-1:0]  regs [`NUM_REGS];
    logic [`XLEN-1:0]  rs1_val;
    logic [`XLEN-1:0]  rs2_val;

    // mem result wins over wb as it is younger
    function automatic logic [`XLEN-1:0] read_src(
        input logic [`REG_AW-1:0] src,
        input logic [`XLEN-1:0]   rf_val,
        input pipe_pkg::fwd_t     mem_f,
        input pipe_pkg::fwd_t     wb_f
    );
        logic [`XLEN-1:0] val;
        val = (src == '0) ? '0 : rf_val;
        if (wb_f.valid && wb_f.rd == src) begin
            val = wb_f.wdata;
        end
        if (mem_f.valid && mem_f.can_forward && mem_f.rd == src) begin
            val = mem_f.wdata;
        end
        return val;
    endfunction

    // writer has no value yet
    function automatic logic blocked(input logic [`REG_AW-1:0] src, input pipe_pkg::fwd_t w);
        return w.valid && !w.can_forward && (w.rd == src);
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            sel_q.valid <= 1'b0;
        end else if (!mem_stall_i && !hazard_o) begin
            sel_q <= ds_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_i.valid && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.wdata;
        end
    end

    assign rs1_val = read_src(sel_q.ctrl.rs1, regs[sel_q.ctrl.rs1], mem_fwd_i, wb_fwd_i);
    assign rs2_val = read_src(sel_q.ctrl.rs2, regs[sel_q.ctrl.rs2], mem_fwd_i, wb_fwd_i);

    assign hazard_o = sel_q.valid &&
                      (blocked(sel_q.ctrl.rs1, ex_busy_i) ||
                       blocked(sel_q.ctrl.rs2, ex_busy_i) ||
                       blocked(sel_q.ctrl.rs1, mem_fwd_i) ||
                       blocked(sel_q.ctrl.rs2, mem_fwd_i));

    always_comb begin
        ex_o.valid    = sel_q.valid;
        ex_o.pc       = sel_q.pc;
        ex_o.ctrl     = sel_q.ctrl;
        ex_o.imm      = sel_q.imm;
        ex_o.rs2_data = rs2_val;
        ex_o.op1      = (sel_q.ctrl.op1_sel == pipe_pkg::OP1_PC) ? sel_q.pc : rs1_val;
        ex_o.op2      = (sel_q.ctrl.op2_sel == pipe_pkg::OP2_IMM) ? sel_q.imm : rs2_val;
    end

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ns
`include "core_cfg.svh"

module decode_unit (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               stall_i,
    input  logic               flush_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  rv_isa_pkg::inst_u  inst_i,
    output pipe_pkg::ds_reg_t  ds_o
);

    logic              id_valid;
    logic [`XLEN-1:0]  id_pc;
    rv_isa_pkg::inst_u id_inst;
    pipe_pkg::ctrl_t   ctrl;
    logic [`XLEN-1:0]  imm;
    logic              legal;

    function automatic rv_isa_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            rv_isa_pkg::F3_ADD: return alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL: return rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT: return rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_XOR: return rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL: return rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:  return rv_isa_pkg::ALU_OR;
            default:            return rv_isa_pkg::ALU_AND;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            id_valid <= 1'b0;
        end else if (!stall_i) begin
            id_valid <= 1'b1;
            id_pc    <= pc_i;
            id_inst  <= inst_i;
        end
    end

    always_comb begin
        ctrl         = '0;
        imm          = '0;
        legal        = 1'b1;
        ctrl.op2_sel = pipe_pkg::OP2_IMM;
        ctrl.rs1     = id_inst.r.rs1;
        ctrl.rs2     = id_inst.r.rs2;
        ctrl.rd      = id_inst.r.rd;
        case (id_inst.r.opcode)
            rv_isa_pkg::OP_REG: begin
                ctrl.op2_sel = pipe_pkg::OP2_RS2;
                ctrl.alu_op  = alu_decode(id_inst.r.funct3,
                                          id_inst.r.funct7 == rv_isa_pkg::F7_ALT);
                ctrl.rf_wen  = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                ctrl.rs2    = '0;
                ctrl.alu_op = alu_decode(id_inst.i.funct3, 1'b0);
                imm         = {{20{id_inst.i.imm11_0[11]}}, id_inst.i.imm11_0};
                ctrl.rf_wen = 1'b1;
            end
            rv_isa_pkg::OP_LUI: begin
                // x0 + upper immediate
                ctrl.rs1    = '0;
                ctrl.rs2    = '0;
                imm         = {id_inst.u.imm31_12, 12'b0};
                ctrl.rf_wen = 1'b1;
            end
            rv_isa_pkg::OP_LOAD: begin
                ctrl.rs2     = '0;
                imm          = {{20{id_inst.i.imm11_0[11]}}, id_inst.i.imm11_0};
                ctrl.mem_ren = 1'b1;
                ctrl.wb_sel  = pipe_pkg::WB_MEM;
                ctrl.rf_wen  = 1'b1;
                legal        = id_inst.i.funct3 == rv_isa_pkg::F3_WORD;
            end
            rv_isa_pkg::OP_STORE: begin
                imm          = {{20{id_inst.s.imm11_5[6]}}, id_inst.s.imm11_5,
                                id_inst.s.imm4_0};
                ctrl.mem_wen = 1'b1;
                legal        = id_inst.s.funct3 == rv_isa_pkg::F3_WORD;
            end
            rv_isa_pkg::OP_BRANCH: begin
                ctrl.op2_sel = pipe_pkg::OP2_RS2;
                imm          = {{19{id_inst.b.imm12}}, id_inst.b.imm12, id_inst.b.imm11,
                                id_inst.b.imm10_5, id_inst.b.imm4_1, 1'b0};
                if (id_inst.b.funct3 == rv_isa_pkg::F3_BEQ) begin
                    ctrl.br_kind = pipe_pkg::BR_EQ;
                end else if (id_inst.b.funct3 == rv_isa_pkg::F3_BNE) begin
                    ctrl.br_kind = pipe_pkg::BR_NE;
                end else begin
                    legal = 1'b0;
                end
            end
            rv_isa_pkg::OP_JAL: begin
                ctrl.rs1     = '0;
                ctrl.rs2     = '0;
                ctrl.op1_sel = pipe_pkg::OP1_PC;
                imm          = {{11{id_inst.j.imm20}}, id_inst.j.imm20, id_inst.j.imm19_12,
                                id_inst.j.imm11, id_inst.j.imm10_1, 1'b0};
                ctrl.jmp     = 1'b1;
                ctrl.wb_sel  = pipe_pkg::WB_PC4;
                ctrl.rf_wen  = 1'b1;
            end
            rv_isa_pkg::OP_JALR: begin
                ctrl.rs2     = '0;
                imm          = {{20{id_inst.i.imm11_0[11]}}, id_inst.i.imm11_0};
                ctrl.jmp_reg = 1'b1;
                ctrl.wb_sel  = pipe_pkg::WB_PC4;
                ctrl.rf_wen  = 1'b1;
            end
            default: legal = 1'b0;
        endcase
        // writes to x0 are dropped here
        ctrl.rf_wen = ctrl.rf_wen && (ctrl.rd != '0);
        if (!legal) begin
            ctrl = '0;
        end
    end

    assign ds_o = '{valid: id_valid && legal, pc: id_pc, ctrl: ctrl, imm: imm};

endmodule

// File: design/pipe_pkg.sv
`include "core_cfg.svh"

package pipe_pkg;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4
    } wb_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } br_kind_e;

    typedef enum logic {
        OP1_RS1,
        OP1_PC
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    typedef struct packed {
        rv_isa_pkg::alu_op_e alu_op;
        op1_sel_e            op1_sel;
        op2_sel_e            op2_sel;
        logic                rf_wen;
        wb_sel_e             wb_sel;
        logic                mem_ren;
        logic                mem_wen;
        br_kind_e            br_kind;
        logic                jmp;
        logic                jmp_reg;
        logic [`REG_AW-1:0]  rs1;
        logic [`REG_AW-1:0]  rs2;
        logic [`REG_AW-1:0]  rd;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        ctrl_t             ctrl;
        logic [`XLEN-1:0]  imm;
    } ds_reg_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        ctrl_t             ctrl;
        logic [`XLEN-1:0]  op1;
        logic [`XLEN-1:0]  op2;
        logic [`XLEN-1:0]  rs2_data;
        logic [`XLEN-1:0]  imm;
    } ex_reg_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        ctrl_t             ctrl;
        logic [`XLEN-1:0]  alu_out;
        logic [`XLEN-1:0]  rs2_data;
    } mem_reg_t;

    typedef struct packed {
        logic               valid;
        logic               can_forward;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   wdata;
    } fwd_t;

    typedef struct packed {
        logic             valid;
        logic             we;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } dreq_t;

    typedef struct packed {
        logic             ready;
        logic [`XLEN-1:0] rdata;
    } dresp_t;

    typedef struct packed {
        logic               valid;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   wdata;
    } retire_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] target;
    } redirect_t;

endpackage

// File: design/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7
    } alu_op_e;

    // funct3 of alu ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    // branch and word access
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;

    // sub instead of add
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    // one instruction word with six format views
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_u;

endpackage

// File: design/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// data and address width
`define XLEN 32

// integer register file
`define NUM_REGS 32
`define REG_AW 5

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif
